//--- common/ro_macros.svh
`ifndef RO_MACROS_SVH
`define RO_MACROS_SVH

// Issue lanes, each with its own buffer
`define RO_IW          2

`define RO_DW          32    // Operand width
`define RO_PRF_AW      6     // 64 physical registers
`define RO_PC_W        30
`define RO_ROB_AW      5     // Reorder-buffer tag

// Opcode field widths
`define RO_ALU_OPC_W   6
`define RO_BRU_OPC_W   4

// Derived sizes
`define RO_PRF_N       (1 << `RO_PRF_AW)
`define RO_NRP         (2 * `RO_IW)    // Two source reads per lane

`endif

//--- common/ro_pkg.sv
`include "ro_macros.svh"

package ro_pkg;

   // Fields that ride through the stage untouched
   typedef struct packed
   {
      logic [`RO_ALU_OPC_W-1:0] alu_opc;
      logic [`RO_BRU_OPC_W-1:0] bru_opc;
      logic                     lsu_op;
      logic [`RO_PC_W-1:0]      pc;        // Also stands in for the predicted target
      logic [`RO_DW-1:0]        imm;
      logic [`RO_PRF_AW-1:0]    prd;
      logic                     prd_we;
      logic [`RO_ROB_AW-1:0]    rob_id;
   } uop_t;

   // Renamed micro-op as issued
   typedef struct packed
   {
      uop_t                     uop;
      logic [`RO_PRF_AW-1:0]    prs1;
      logic                     prs1_re;
      logic [`RO_PRF_AW-1:0]    prs2;
      logic                     prs2_re;
   } ro_req_t;

   // Micro-op toward execute, operands attached
   typedef struct packed
   {
      uop_t                     uop;
      logic [`RO_DW-1:0]        operand1;
      logic [`RO_DW-1:0]        operand2;
   } ex_uop_t;

   typedef struct packed
   {
      logic                     re;
      logic [`RO_PRF_AW-1:0]    addr;
   } prf_rd_t;

   // Writeback, no handshake
   typedef struct packed
   {
      logic                     we;
      logic [`RO_PRF_AW-1:0]    addr;
      logic [`RO_DW-1:0]        data;
   } prf_wr_t;

endpackage

//--- hw/lane_buf.sv
`timescale 1ns/1ps

module lane_buf
(
   input  logic          clk,
   input  logic          rst_n,
   input  logic          flush,
   // Upstream handshake
   input  logic          in_valid,
   output logic          in_ready,
   // Downstream handshake
   output logic          out_valid,
   input  logic          out_ready,
   output logic          load,      // Accept strobe, used for side registers
   input  ro_pkg::uop_t  d,
   output ro_pkg::uop_t  q
);
   import ro_pkg::*;

   logic  valid_q;
   uop_t  data_q;

   // Ready passes straight through from downstream
   assign in_ready  = ~valid_q | out_ready;
   assign load      = in_valid & in_ready & ~flush;
   assign out_valid = valid_q;
   assign q         = data_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q <= 1'b0;
      end
      else if (flush)
      begin
         valid_q <= 1'b0;   // Drops held and offered entries
      end
      else if (in_ready)
      begin
         // Empty or draining, so refill or go empty
         valid_q <= in_valid;
      end
   end

   // Payload only moves on accept
   always_ff @(posedge clk)
   begin
      if (load)
      begin
         data_q <= d;
      end
   end

endmodule

//--- prf/prf.sv
`timescale 1ns/1ps
`include "ro_macros.svh"

module prf
(
   input  logic                             clk,
   input  logic                             rst_n,
   // Two read ports per lane
   input  ro_pkg::prf_rd_t [`RO_NRP-1:0]    rd,
   output logic [`RO_NRP-1:0][`RO_DW-1:0]   rdata,
   // Writeback ports
   input  ro_pkg::prf_wr_t [`RO_IW-1:0]     wr
);
   import ro_pkg::*;

   logic [`RO_DW-1:0]               regs [`RO_PRF_N];
   logic [`RO_NRP-1:0][`RO_DW-1:0]  rd_fwd;   // Array value or same-cycle write

   // Write-first read of one port against all writers
   function automatic logic [`RO_DW-1:0] read_fwd
   (
      input prf_rd_t                   port,
      input logic [`RO_DW-1:0]         stored,
      input prf_wr_t [`RO_IW-1:0]      w
   );
      logic [`RO_DW-1:0] val;
      val = stored;
      // Later ports overwrite earlier matches
      for (int k = 0; k < `RO_IW; k++)
      begin
         if (w[k].we && (w[k].addr == port.addr))
         begin
            val = w[k].data;
         end
      end
      return val;
   endfunction

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int r = 0; r < `RO_PRF_N; r++)
         begin
            regs[r] <= '0;
         end
      end
      else
      begin
         // Last assignment wins, so the highest port takes a collision
         for (int k = 0; k < `RO_IW; k++)
         begin
            if (wr[k].we)
            begin
               regs[wr[k].addr] <= wr[k].data;
            end
         end
      end
   end

   always_comb
   begin
      for (int p = 0; p < `RO_NRP; p++)
      begin
         rd_fwd[p] = read_fwd(rd[p], regs[rd[p].addr], wr);
      end
   end

   // Read data only loads on enable
   // Keeps operands steady while execute stalls
   always_ff @(posedge clk)
   begin
      for (int p = 0; p < `RO_NRP; p++)
      begin
         if (rd[p].re)
         begin
            rdata[p] <= rd_fwd[p];
         end
      end
   end

endmodule

//--- ro/ro_stage.sv
`timescale 1ns/1ps
`include "ro_macros.svh"

module ro_stage
(
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             flush,
   // From issue
   input  ro_pkg::ro_req_t [`RO_IW-1:0]     issue_req,
   input  logic [`RO_IW-1:0]                issue_valid,
   output logic [`RO_IW-1:0]                issue_ready,
   // To register file
   output ro_pkg::prf_rd_t [`RO_NRP-1:0]    prf_rd,
   // From register file, one cycle after the request
   input  logic [`RO_NRP-1:0][`RO_DW-1:0]   prf_rdata,
   // To execute
   output ro_pkg::ex_uop_t [`RO_IW-1:0]     ex_uop,
   output logic [`RO_IW-1:0]                ex_valid,
   input  logic [`RO_IW-1:0]                ex_ready
);
   import ro_pkg::*;

   logic [`RO_IW-1:0]  lane_load;   // Accept strobe per lane
   uop_t [`RO_IW-1:0]  lane_uop;    // Buffered pass-through fields

   genvar i;

   generate
      for (i = 0; i < `RO_IW; i++)
      begin : gen_lane
         lane_buf lane_buf_inst
         (
            .clk       (clk),
            .rst_n     (rst_n),
            .flush     (flush),
            .in_valid  (issue_valid[i]),
            .in_ready  (issue_ready[i]),
            .out_valid (ex_valid[i]),
            .out_ready (ex_ready[i]),
            .load      (lane_load[i]),
            .d         (issue_req[i].uop),
            .q         (lane_uop[i])
         );

         // Register file acts as the operand half of this stage
         // Reads fire only on accept
         always_comb
         begin
            prf_rd[2*i].re     = issue_req[i].prs1_re & lane_load[i];
            prf_rd[2*i].addr   = issue_req[i].prs1;
            prf_rd[2*i+1].re   = issue_req[i].prs2_re & lane_load[i];
            prf_rd[2*i+1].addr = issue_req[i].prs2;
         end

         // Operands come straight from the read registers
         always_comb
         begin
            ex_uop[i].uop      = lane_uop[i];
            ex_uop[i].operand1 = prf_rdata[2*i];     // rs1 port
            ex_uop[i].operand2 = prf_rdata[2*i+1];   // rs2 port
         end
      end
   endgenerate

endmodule

//--- hw/operand_read_top.sv
`timescale 1ns/1ps
`include "ro_macros.svh"

module operand_read_top
(
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             flush,
   // Issue side
   input  ro_pkg::ro_req_t [`RO_IW-1:0]     issue_req,
   input  logic [`RO_IW-1:0]                issue_valid,
   output logic [`RO_IW-1:0]                issue_ready,
   // Writeback ports, always applied
   input  ro_pkg::prf_wr_t [`RO_IW-1:0]     wb,
   // Execute side
   output ro_pkg::ex_uop_t [`RO_IW-1:0]     ex_uop,
   output logic [`RO_IW-1:0]                ex_valid,
   input  logic [`RO_IW-1:0]                ex_ready
);

   ro_pkg::prf_rd_t [`RO_NRP-1:0]    prf_rd;
   logic [`RO_NRP-1:0][`RO_DW-1:0]   prf_rdata;

   ro_stage ro_stage_inst
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush        (flush),
      .issue_req    (issue_req),
      .issue_valid  (issue_valid),
      .issue_ready  (issue_ready),
      .prf_rd       (prf_rd),
      .prf_rdata    (prf_rdata),
      .ex_uop       (ex_uop),
      .ex_valid     (ex_valid),
      .ex_ready     (ex_ready)
   );

   // Physical register file, written by writeback
   prf prf_inst
   (
      .clk    (clk),
      .rst_n  (rst_n),
      .rd     (prf_rd),
      .rdata  (prf_rdata),
      .wr     (wb)
   );

endmodule

//--- tests/ro_checker.sv
`timescale 1ns/1ps
`include "ro_macros.svh"

module ro_checker
(
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             flush,
   input  ro_pkg::ro_req_t [`RO_IW-1:0]     issue_req,
   input  logic [`RO_IW-1:0]                issue_valid,
   input  logic [`RO_IW-1:0]                issue_ready,
   input  ro_pkg::prf_wr_t [`RO_IW-1:0]     wb,
   input  ro_pkg::ex_uop_t [`RO_IW-1:0]     ex_uop,
   input  logic [`RO_IW-1:0]                ex_valid,
   input  logic [`RO_IW-1:0]                ex_ready,
   input  logic [2:0]                       phase,
   output int                               checks,
   output int                               errors
);
   import ro_pkg::*;

   // Expected delivery and which operands carry meaning
   typedef struct packed
   {
      ex_uop_t  val;
      logic     use1;
      logic     use2;
   } expect_t;

   logic [`RO_DW-1:0]  shadow [`RO_PRF_N];   // Architectural view of the PRF
   expect_t            pend [`RO_IW][$];     // Oldest first in each lane
   expect_t            head;
   logic               busy;
   int                 n_checks = 0;
   int                 n_errors = 0;

   assign checks = n_checks;
   assign errors = n_errors;

   function automatic string phase_name(input logic [2:0] p);
      case (p)
         3'd1:    return "reset";
         3'd2:    return "passthrough";
         3'd3:    return "forwarding";
         3'd4:    return "backpressure";
         3'd5:    return "flush";
         3'd6:    return "lanes";
         default: return "idle";
      endcase
   endfunction

   // Value a read sees at this edge with the newest writer first
   function automatic logic [`RO_DW-1:0] src_value
   (
      input logic [`RO_PRF_AW-1:0]  addr,
      input prf_wr_t [`RO_IW-1:0]   w
   );
      for (int k = `RO_IW - 1; k >= 0; k--)
      begin
         if (w[k].we && (w[k].addr == addr))
         begin
            return w[k].data;
         end
      end
      return shadow[addr];
   endfunction

   // Reference model of one accepted micro-op
   function automatic expect_t ref_uop(input ro_req_t req, input prf_wr_t [`RO_IW-1:0] w);
      expect_t e;
      e.val.uop      = req.uop;
      e.val.operand1 = src_value(req.prs1, w);
      e.val.operand2 = src_value(req.prs2, w);
      e.use1         = req.prs1_re;
      e.use2         = req.prs2_re;
      return e;
   endfunction

   task automatic check_value
   (
      input string         what,
      input int            lane,
      input logic [127:0]  exp,
      input logic [127:0]  act
   );
      n_checks++;
      if (exp !== act)
      begin
         n_errors++;
         $display("mismatch %s lane %0d %s expected %0h actual %0h",
                  phase_name(phase), lane, what, exp, act);
      end
   endtask

   task automatic report_fault(input int lane, input string what);
      n_checks++;
      n_errors++;
      $display("%s: lane %0d %s", phase_name(phase), lane, what);
   endtask

   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int r = 0; r < `RO_PRF_N; r++)
         begin
            shadow[r] = '0;
         end
         for (int i = 0; i < `RO_IW; i++)
         begin
            pend[i].delete();
         end
      end
      else
      begin
         for (int i = 0; i < `RO_IW; i++)
         begin
            busy = (pend[i].size() != 0);
            check_value("ex_valid", i, 128'(busy), 128'(ex_valid[i]));
            check_value("issue_ready", i, 128'(!busy || ex_ready[i]), 128'(issue_ready[i]));
            // Held entries are compared every cycle so stalls must keep them steady
            if (ex_valid[i] && busy)
            begin
               head = pend[i][0];
               check_value("uop", i, 128'(head.val.uop), 128'(ex_uop[i].uop));
               if (head.use1)
               begin
                  check_value("operand1", i, 128'(head.val.operand1), 128'(ex_uop[i].operand1));
               end
               if (head.use2)
               begin
                  check_value("operand2", i, 128'(head.val.operand2), 128'(ex_uop[i].operand2));
               end
            end
            if (ex_valid[i] && ex_ready[i])
            begin
               if (!busy)
               begin
                  report_fault(i, "delivered a micro-op that was never accepted");
               end
               else
               begin
                  void'(pend[i].pop_front());
               end
            end
            if (flush)
            begin
               pend[i].delete();   // Offered and held entries die here
            end
            else if (issue_valid[i] && issue_ready[i])
            begin
               if (pend[i].size() != 0)
               begin
                  report_fault(i, "accepted a micro-op while still full");
               end
               pend[i].push_back(ref_uop(issue_req[i], wb));
            end
         end
         // Writebacks land after this edge's reads with the higher port last
         for (int k = 0; k < `RO_IW; k++)
         begin
            if (wb[k].we)
            begin
               shadow[wb[k].addr] = wb[k].data;
            end
         end
      end
   end

endmodule

//--- tests/tb_operand_read.sv
`timescale 1ns/1ps
`include "ro_macros.svh"

module tb_operand_read;
   import ro_pkg::*;

   localparam int DRAIN_LIMIT = 50;

   logic                   clk = 1'b0;
   logic                   rst_n;
   logic                   flush;
   ro_req_t [`RO_IW-1:0]   issue_req;
   logic [`RO_IW-1:0]      issue_valid;
   logic [`RO_IW-1:0]      issue_ready;
   prf_wr_t [`RO_IW-1:0]   wb;
   ex_uop_t [`RO_IW-1:0]   ex_uop;
   logic [`RO_IW-1:0]      ex_valid;
   logic [`RO_IW-1:0]      ex_ready;
   logic [2:0]             phase;
   int                     checks;
   int                     errors;
   int                     timeouts;
   int                     checks_mark;
   int                     errors_mark;
   int                     timeouts_mark;

   // Stimulus knobs, set per phase
   logic                   use_issue;
   logic                   use_wb;
   logic                   rand_ready;   // Else ex_ready held high
   logic                   use_flush;
   logic [`RO_PRF_AW-1:0]  addr_mask;    // Narrow mask makes address hits likely

   logic [31:0]            lfsr = 32'd23352;

   always #4 clk = ~clk;

   operand_read_top operand_read_top_inst
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush        (flush),
      .issue_req    (issue_req),
      .issue_valid  (issue_valid),
      .issue_ready  (issue_ready),
      .wb           (wb),
      .ex_uop       (ex_uop),
      .ex_valid     (ex_valid),
      .ex_ready     (ex_ready)
   );

   ro_checker checker_inst
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush        (flush),
      .issue_req    (issue_req),
      .issue_valid  (issue_valid),
      .issue_ready  (issue_ready),
      .wb           (wb),
      .ex_uop       (ex_uop),
      .ex_valid     (ex_valid),
      .ex_ready     (ex_ready),
      .phase        (phase),
      .checks       (checks),
      .errors       (errors)
   );

   // Galois form, right shift
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
      begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   function automatic logic rand_bit();
      logic b;
      b    = lfsr[0];
      lfsr = lfsr_next(lfsr);
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int b = 0; b < n; b++)
      begin
         v = {v[30:0], rand_bit()};
      end
      return v;
   endfunction

   // One falling edge worth of inputs
   task automatic drive_cycle();
      for (int i = 0; i < `RO_IW; i++)
      begin
         issue_valid[i]           = use_issue & (rand_bits(2) != 0);
         issue_req[i].prs1        = `RO_PRF_AW'(rand_bits(`RO_PRF_AW)) & addr_mask;
         issue_req[i].prs1_re     = rand_bit();
         issue_req[i].prs2        = `RO_PRF_AW'(rand_bits(`RO_PRF_AW)) & addr_mask;
         issue_req[i].prs2_re     = rand_bit();
         issue_req[i].uop.alu_opc = `RO_ALU_OPC_W'(rand_bits(`RO_ALU_OPC_W));
         issue_req[i].uop.bru_opc = `RO_BRU_OPC_W'(rand_bits(`RO_BRU_OPC_W));
         issue_req[i].uop.lsu_op  = rand_bit();
         issue_req[i].uop.pc      = `RO_PC_W'(rand_bits(`RO_PC_W));
         issue_req[i].uop.imm     = `RO_DW'(rand_bits(`RO_DW));
         issue_req[i].uop.prd     = `RO_PRF_AW'(rand_bits(`RO_PRF_AW));
         issue_req[i].uop.prd_we  = rand_bit();
         issue_req[i].uop.rob_id  = `RO_ROB_AW'(rand_bits(`RO_ROB_AW));
         ex_ready[i]              = ~rand_ready | (rand_bits(4) < 11);   // About 70 %
      end
      for (int k = 0; k < `RO_IW; k++)
      begin
         wb[k].we   = use_wb & rand_bit();
         wb[k].addr = `RO_PRF_AW'(rand_bits(`RO_PRF_AW)) & addr_mask;
         wb[k].data = `RO_DW'(rand_bits(`RO_DW));
      end
      flush = use_flush & (rand_bits(5) == 0);
   endtask

   task automatic run_cycles(input int n);
      repeat (n)
      begin
         @(negedge clk);
         drive_cycle();
      end
   endtask

   task automatic begin_phase
   (
      input logic [2:0]             p,
      input logic                   issue_on,
      input logic                   wb_on,
      input logic                   ready_on,
      input logic                   flush_on,
      input logic [`RO_PRF_AW-1:0]  mask
   );
      phase         = p;
      use_issue     = issue_on;
      use_wb        = wb_on;
      rand_ready    = ready_on;
      use_flush     = flush_on;
      addr_mask     = mask;
      checks_mark   = checks;
      errors_mark   = errors;
      timeouts_mark = timeouts;
   endtask

   // Stop issuing and wait for every lane to empty
   task automatic drain_lanes();
      int n;
      n          = 0;
      use_issue  = 1'b0;
      use_wb     = 1'b0;
      use_flush  = 1'b0;
      rand_ready = 1'b0;
      run_cycles(1);
      while ((ex_valid != '0) && (n < DRAIN_LIMIT))
      begin
         run_cycles(1);
         n++;
      end
      if (ex_valid != '0)
      begin
         timeouts++;
         $display("timeout: lanes still hold micro-ops after %0d drain cycles", DRAIN_LIMIT);
      end
   endtask

   task automatic end_phase(input string name);
      $display("phase %s done: %0d checks, %0d errors, %0d timeouts", name,
               checks - checks_mark, errors - errors_mark, timeouts - timeouts_mark);
   endtask

   initial
   begin
      rst_n    = 1'b0;
      timeouts = 0;
      begin_phase(3'd0, 1'b0, 1'b0, 1'b0, 1'b0, '1);
      drive_cycle();
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Idle, then reads of a file that holds only zeros
      begin_phase(3'd1, 1'b0, 1'b0, 1'b0, 1'b0, '1);
      run_cycles(4);
      use_issue = 1'b1;
      run_cycles(40);
      drain_lanes();
      end_phase("reset");

      begin_phase(3'd2, 1'b0, 1'b1, 1'b0, 1'b0, '1);
      run_cycles(80);           // Fill registers first
      use_wb    = 1'b0;
      use_issue = 1'b1;
      run_cycles(200);
      drain_lanes();
      end_phase("passthrough");

      begin_phase(3'd3, 1'b1, 1'b1, 1'b0, 1'b0, 6'h07);
      run_cycles(300);
      drain_lanes();
      end_phase("forwarding");

      begin_phase(3'd4, 1'b1, 1'b1, 1'b1, 1'b0, 6'h07);
      run_cycles(400);
      drain_lanes();
      end_phase("backpressure");

      begin_phase(3'd5, 1'b1, 1'b1, 1'b1, 1'b1, 6'h0f);
      run_cycles(400);
      drain_lanes();
      end_phase("flush");

      begin_phase(3'd6, 1'b1, 1'b1, 1'b1, 1'b0, '1);
      run_cycles(600);
      drain_lanes();
      end_phase("lanes");

      $display("checks passed %0d, failed %0d", checks - errors, errors + timeouts);
      if ((errors == 0) && (timeouts == 0))
      begin
         $display("Testbench passed");
      end
      else
      begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- all.f
+incdir+common
common/ro_pkg.sv
hw/lane_buf.sv
prf/prf.sv
ro/ro_stage.sv
hw/operand_read_top.sv
tests/ro_checker.sv
tests/tb_operand_read.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run, the exit status follows the testbench result
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f all.f \
   --top-module tb_operand_read -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -x "Testbench passed" > /dev/null &&
echo "run.sh: PASS" ||
{ echo "run.sh: FAIL"; exit 1; }
